// File: Makefile
# Verilator build of the command tree testbench

SIM = obj_dir/routeTreeSim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f project.f --top-module routeTreeTb \
		-Mdir obj_dir -o routeTreeSim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: dv/routeTreeTb.sv
// Command tree testbench
// Directed and LCG sessions against a per-leaf accumulator model
`timescale 1ns/1ps
`include "tree_macros.svh"

module routeTreeTb
	import treePkg::*;
;

	localparam int Sessions   = 48;              // 8 directed, 40 random
	localparam int MaxWords   = 32 + 40 * 10;
	localparam int CycleLimit = MaxWords + 8 * Sessions + 100;

	logic  clock = 1'b0;
	logic  reset;
	logic  reqIn;
	logic  rlsIn;
	word_t dataIn;
	logic  reqOut;
	logic  rlsOut;
	word_t dataOut;

	logic [31:0] seed;
	string       testName;
	int          cycle = 0;                   // Rising edges so far
	acc_t        accModel [`LEAF_COUNT];
	word_t       expWords [$];
	int          expCycles [$];
	opCode_t     opList [$];
	acc_t        valList [$];
	int          rlsWanted = 0;               // Releases sent
	int          rlsSeen = 0;                 // Releases returned
	int          rlsCycle = 0;

	routeTree DUT (
		.clock, .reset, .reqIn, .rlsIn, .dataIn,
		.reqOut, .rlsOut, .dataOut
	);

	always #20 clock = ~clock;

	////////////////////////////////////////
	// Helpers
	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic acc_t applyOp(input acc_t acc, input opCode_t op, input acc_t val);
		case (op)
			OP_LOAD: return val;
			OP_ADD:  return acc + val;               // Wraps at 16 bits
			OP_SUB:  return acc - val;
			default: return acc ^ val;
		endcase
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			abortRun($sformatf("ERR %s %s: expected %h, actual %h",
				testName, what, expected, actual));
		end
	endtask

	task automatic driveCycle(input logic req, input logic rls, input word_t data);
		reqIn  = req;
		rlsIn  = rls;
		dataIn = data;
		@(posedge clock);
		#1;
	endtask

	task automatic addCmd(input opCode_t op, input acc_t val);
		opList.push_back(op);
		valList.push_back(val);
	endtask

	// Header, queued commands back to back, release, then wait for the release to return
	task automatic runSession(input leafId_t leaf);
		logic [31:0] r;
		opCode_t     op;
		acc_t        val;
		r = nextRand();
		driveCycle(1'b1, 1'b0, {r[31:2], leaf});
		while (opList.size() > 0) begin
			op  = opList.pop_front();
			val = valList.pop_front();
			r   = nextRand();
			accModel[leaf] = applyOp(accModel[leaf], op, val);
			expWords.push_back({14'd0, leaf, accModel[leaf]});
			expCycles.push_back(cycle + 8);        // Sampled next edge, result 7 later
			driveCycle(1'b1, 1'b0, {op, r[29:16], val});
		end
		rlsCycle  = cycle + 8;
		rlsWanted = rlsWanted + 1;
		driveCycle(1'b0, 1'b1, '0);
		rlsIn = 1'b0;
		accModel[leaf] = '0;                      // Leaf starts fresh next time
		while (rlsSeen != rlsWanted) begin
			@(posedge clock);
			#1;
		end
	endtask

	////////////////////////////////////////
	// Compare process
	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle > CycleLimit) begin
			abortRun("Timeout: the tree stopped returning results or releases");
		end
		else if (!reset && reqOut && expWords.size() == 0) begin
			abortRun("A result word came back with no command outstanding");
		end
		else if (!reset && reqOut) begin
			checkValue("result", expWords.pop_front(), dataOut);
			checkValue("latency", expCycles.pop_front(), cycle);
		end
		if (!reset && rlsOut) begin
			rlsSeen = rlsSeen + 1;
			checkValue("release count", rlsWanted, rlsSeen);
			checkValue("release cycle", rlsCycle, cycle);
			checkValue("results before release", 0, expWords.size());
		end
		else if (rlsSeen != rlsWanted && cycle > rlsCycle) begin
			abortRun("The release token did not come back on time");
		end
	end

	////////////////////////////////////////
	// Stimulus
	initial begin
		logic [31:0] r;
		logic [31:0] v;
		int          n;
		reqIn  = 1'b0;
		rlsIn  = 1'b0;
		dataIn = '0;
		reset  = 1'b1;
		seed   = 32'hc008;
		for (int l = 0; l < `LEAF_COUNT; l++) begin
			accModel[l] = '0;
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		testName = "routing";
		for (int l = 0; l < `LEAF_COUNT; l++) begin
			addCmd(OP_LOAD, acc_t'(16'h1111 * l + 7));
			addCmd(OP_ADD, 16'h0101);
			runSession(leafId_t'(l));
		end

		testName = "arithmetic";
		addCmd(OP_LOAD, 16'hfff0);
		addCmd(OP_ADD, 16'h0020);                 // Wraps past the top
		addCmd(OP_SUB, 16'h0030);                 // Wraps below zero
		addCmd(OP_XOR, 16'ha5a5);
		addCmd(OP_SUB, 16'hffff);
		addCmd(OP_ADD, 16'hffff);
		runSession(2'd2);

		testName = "session state";
		addCmd(OP_ADD, 16'h0005);                 // Only correct from a cleared leaf
		runSession(2'd2);
		runSession(2'd1);                         // Header alone, no result
		addCmd(OP_XOR, 16'h1234);
		runSession(2'd1);

		testName = "random";
		for (int s = 0; s < 40; s++) begin
			r = nextRand();
			n = int'(r[26:24]) + 1;
			for (int c = 0; c < n; c++) begin
				r = nextRand();
				v = nextRand();
				addCmd(opCode_t'(r[31:30]), v[31:16]);
			end
			r = nextRand();
			runSession(leafId_t'(r[21:20]));
		end

		testName = "end of run";
		checkValue("results left", 0, expWords.size());
		$display("Regression passed");
		$finish;
	end

endmodule

// File: project.f
+incdir+source
source/treePkg.sv
source/router.sv
source/cmdDecode.sv
source/accExecute.sv
source/resultReturn.sv
source/leafNode.sv
source/routeTree.sv
dv/routeTreeTb.sv

// File: source/accExecute.sv
// Execute stage of a leaf
// Applies load, add, subtract and xor to a 16-bit accumulator
`timescale 1ns/1ps

module accExecute
	import treePkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    cmdValid,
	input  opCode_t opCode,
	input  acc_t    operand,
	input  logic    rlsIn,
	output logic    resValid,
	output acc_t    accValue,             // Accumulator, also the result
	output logic    rlsOut
);

	acc_t accNext;

	// Arithmetic wraps modulo 2^16
	always_comb begin
		accNext = accValue;
		case (opCode)
			OP_LOAD: accNext = operand;
			OP_ADD:  accNext = accValue + operand;
			OP_SUB:  accNext = accValue - operand;
			OP_XOR:  accNext = accValue ^ operand;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			accValue <= '0;
			resValid <= 1'b0;
			rlsOut   <= 1'b0;
		end
		else begin
			resValid <= cmdValid;
			rlsOut   <= rlsIn;
			if (rlsIn) begin
				accValue <= '0;              // Fresh state for the next session
			end
			else if (cmdValid) begin
				accValue <= accNext;
			end
		end
	end

	// Host never sends a command together with the release
	assert property (@(posedge clock) disable iff (reset) !(cmdValid && rlsIn));

endmodule

// File: source/cmdDecode.sv
// Command decode stage of a leaf
// Drops the session header and splits commands into opcode and operand
`timescale 1ns/1ps

module cmdDecode
	import treePkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    reqIn,
	input  logic    rlsIn,
	input  word_t   dataIn,
	output logic    cmdValid,
	output opCode_t opCode,
	output acc_t    operand,
	output logic    rlsOut
);

	logic     headerNext;                 // Next word is a header
	cmdWord_t cmdWord;

	assign cmdWord = dataIn;

	always_ff @(posedge clock) begin
		if (reset) begin
			headerNext <= 1'b1;
			cmdValid   <= 1'b0;
			rlsOut     <= 1'b0;
		end
		else begin
			cmdValid <= reqIn & ~headerNext;
			rlsOut   <= rlsIn;
			if (rlsIn) begin
				headerNext <= 1'b1;          // Rearm for the next session
			end
			else if (reqIn) begin
				headerNext <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reqIn & ~headerNext) begin
			opCode  <= cmdWord.op;
			operand <= cmdWord.operand;
		end
	end

endmodule

// File: source/leafNode.sv
// One leaf of the command tree
// Decode, execute and result stages in a row
`timescale 1ns/1ps

module leafNode
	import treePkg::*;
#(
	parameter int leafNumber = 0
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  reqIn,
	input  logic  rlsIn,
	input  word_t dataIn,
	output logic  reqOut,
	output logic  rlsOut,
	output word_t dataOut
);

	logic    cmdValid;
	opCode_t opCode;
	acc_t    operand;
	logic    decRls;                      // Release after decode
	logic    resValid;
	acc_t    accValue;
	logic    exeRls;                      // Release after execute

	cmdDecode decode (
		.clock, .reset, .reqIn, .rlsIn, .dataIn,
		.cmdValid, .opCode, .operand, .rlsOut(decRls)
	);

	accExecute execute (
		.clock, .reset, .cmdValid, .opCode, .operand, .rlsIn(decRls),
		.resValid, .accValue, .rlsOut(exeRls)
	);

	resultReturn #(.leafNumber(leafNumber)) result (
		.clock, .reset, .resValid, .accValue, .rlsIn(exeRls),
		.reqOut, .rlsOut, .dataOut
	);

endmodule

// File: source/resultReturn.sv
// Result stage of a leaf
// Tags each accumulator value with the leaf number and sends the release behind it
`timescale 1ns/1ps

module resultReturn
	import treePkg::*;
#(
	parameter int leafNumber = 0
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  resValid,
	input  acc_t  accValue,
	input  logic  rlsIn,
	output logic  reqOut,
	output logic  rlsOut,
	output word_t dataOut
);

	result_t resultWord;

	always_comb begin
		resultWord      = '0;
		resultWord.leaf = leafId_t'(leafNumber);
		resultWord.acc  = accValue;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			reqOut <= 1'b0;
			rlsOut <= 1'b0;
		end
		else begin
			reqOut <= resValid;
			rlsOut <= rlsIn;                // Follows the last result up the path
		end
	end

	always_ff @(posedge clock) begin
		if (resValid) begin
			dataOut <= resultWord;
		end
	end

endmodule

// File: source/routeTree.sv
// Command tree top level
// Root router, two level-0 routers and four accumulator leaves
`timescale 1ns/1ps
`include "tree_macros.svh"

module routeTree
	import treePkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  reqIn,
	input  logic  rlsIn,
	input  word_t dataIn,
	output logic  reqOut,
	output logic  rlsOut,
	output word_t dataOut
);

	localparam int MidCount = `LEAF_COUNT / 2;

	// Root to level-0 links, index 0 serves leaves 0 and 1
	logic [MidCount-1:0]   midReq, midRls, midReqBack, midRlsBack;
	word_t                 midData [MidCount];
	word_t                 midDataBack [MidCount];

	// Level-0 to leaf links
	logic [`LEAF_COUNT-1:0] leafReq, leafRls, leafReqBack, leafRlsBack;
	word_t                  leafData [`LEAF_COUNT];
	word_t                  leafDataBack [`LEAF_COUNT];

	router #(.selectBit(`TREE_LEVELS - 1)) rootRouter (
		.clock, .reset, .reqIn, .rlsIn, .dataIn,
		.reqA(midReq[0]), .reqB(midReq[1]), .rlsA(midRls[0]), .rlsB(midRls[1]),
		.dataA(midData[0]), .dataB(midData[1]),
		.reqBack(reqOut), .rlsBack(rlsOut), .dataBack(dataOut),
		.reqFromA(midReqBack[0]), .reqFromB(midReqBack[1]),
		.rlsFromA(midRlsBack[0]), .rlsFromB(midRlsBack[1]),
		.dataFromA(midDataBack[0]), .dataFromB(midDataBack[1])
	);

	for (genvar g = 0; g < MidCount; g++) begin : gMid
		router #(.selectBit(0)) midRouter (  // Even leaf on A, odd leaf on B
			.clock, .reset,
			.reqIn(midReq[g]), .rlsIn(midRls[g]), .dataIn(midData[g]),
			.reqA(leafReq[2*g]), .reqB(leafReq[2*g+1]),
			.rlsA(leafRls[2*g]), .rlsB(leafRls[2*g+1]),
			.dataA(leafData[2*g]), .dataB(leafData[2*g+1]),
			.reqBack(midReqBack[g]), .rlsBack(midRlsBack[g]), .dataBack(midDataBack[g]),
			.reqFromA(leafReqBack[2*g]), .reqFromB(leafReqBack[2*g+1]),
			.rlsFromA(leafRlsBack[2*g]), .rlsFromB(leafRlsBack[2*g+1]),
			.dataFromA(leafDataBack[2*g]), .dataFromB(leafDataBack[2*g+1])
		);
	end

	for (genvar i = 0; i < `LEAF_COUNT; i++) begin : gLeaf
		leafNode #(.leafNumber(i)) leaf (
			.clock, .reset,
			.reqIn(leafReq[i]), .rlsIn(leafRls[i]), .dataIn(leafData[i]),
			.reqOut(leafReqBack[i]), .rlsOut(leafRlsBack[i]), .dataOut(leafDataBack[i])
		);
	end

endmodule

// File: source/router.sv
// Two-way session switch
// Steers a session to one branch on its header and returns that branch's traffic
`timescale 1ns/1ps

module router
	import treePkg::*;
#(
	parameter int selectBit = 0           // Header bit that picks branch B
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  reqIn,                  // Forward request from the parent
	input  logic  rlsIn,                  // Forward release from the parent
	input  word_t dataIn,
	output logic  reqA,
	output logic  reqB,
	output logic  rlsA,
	output logic  rlsB,
	output word_t dataA,
	output word_t dataB,
	output logic  reqBack,                // Backward request toward the parent
	output logic  rlsBack,
	output word_t dataBack,
	input  logic  reqFromA,
	input  logic  reqFromB,
	input  logic  rlsFromA,
	input  logic  rlsFromB,
	input  word_t dataFromA,
	input  word_t dataFromB
);

	logic run;                            // Session open
	logic branchB;                        // Session goes to branch B
	logic pickB;                          // Branch for the word on dataIn
	logic rlsReturn;                      // Release coming back up

	assign pickB     = run ? branchB : dataIn[selectBit];
	assign rlsReturn = branchB ? rlsFromB : rlsFromA;

	////////////////////////////////////////
	// Session state
	always_ff @(posedge clock) begin
		if (reset) begin
			run     <= 1'b0;
			branchB <= 1'b0;
		end
		else if (~run & reqIn) begin
			run     <= 1'b1;                 // Header opens the session
			branchB <= dataIn[selectBit];
		end
		else if (run & rlsReturn) begin
			run     <= 1'b0;                 // Path free once release is back
		end
	end

	////////////////////////////////////////
	// Forward path
	always_ff @(posedge clock) begin
		if (reset) begin
			reqA <= 1'b0;
			reqB <= 1'b0;
			rlsA <= 1'b0;
			rlsB <= 1'b0;
		end
		else begin
			reqA <= reqIn & ~pickB;
			reqB <= reqIn & pickB;
			rlsA <= run & rlsIn & ~branchB;  // Release only inside a session
			rlsB <= run & rlsIn & branchB;
		end
	end

	always_ff @(posedge clock) begin
		if (reqIn & ~pickB) begin
			dataA <= dataIn;
		end
		if (reqIn & pickB) begin
			dataB <= dataIn;
		end
	end

	////////////////////////////////////////
	// Backward path
	always_ff @(posedge clock) begin
		if (reset) begin
			reqBack <= 1'b0;
			rlsBack <= 1'b0;
		end
		else begin
			reqBack <= run & (branchB ? reqFromB : reqFromA);
			rlsBack <= run & rlsReturn;
		end
	end

	always_ff @(posedge clock) begin
		dataBack <= branchB ? dataFromB : dataFromA;
	end

	// Release arrives inside an open session and never with a request
	assert property (@(posedge clock) disable iff (reset) rlsIn |-> run && !reqIn);
	// Results only from the chosen branch
	assert property (@(posedge clock) disable iff (reset)
		run |-> !(branchB ? reqFromA : reqFromB));

endmodule

// File: source/treePkg.sv
// Command tree types
// Link word, opcodes and the command and result word layouts
`include "tree_macros.svh"

package treePkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [15:0] acc_t;
	typedef logic [$clog2(`LEAF_COUNT)-1:0] leafId_t;

	typedef enum logic [1:0] {
		OP_LOAD = 2'd0,
		OP_ADD  = 2'd1,
		OP_SUB  = 2'd2,
		OP_XOR  = 2'd3
	} opCode_t;

	// Command word, opcode in bits 31:30 and operand in bits 15:0
	typedef struct packed {
		opCode_t                 op;
		logic [`DATA_WIDTH-19:0] unused;
		acc_t                    operand;
	} cmdWord_t;

	// Result word, zero padded above the leaf number
	typedef struct packed {
		logic [`DATA_WIDTH-19:0] pad;
		leafId_t                 leaf;
		acc_t                    acc;
	} result_t;

endpackage

// File: source/tree_macros.svh
// Command tree dimensions
// Shared by the package and the top level
`ifndef TREE_MACROS_SVH
`define TREE_MACROS_SVH

// Word width on every forward and backward link
`define DATA_WIDTH 32

// Router levels between the host and the leaves
`define TREE_LEVELS 2

// Leaves at the bottom of the tree
`define LEAF_COUNT 4

`endif
